// File: tb.f
src/core_pkg.sv
src/uop_pkg.sv
src/decode_stage.sv
src/regfile.sv
src/reg_read_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/int_pipe_top.sv
tb/int_pipe_checker.sv
tb/tb_int_pipe.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_int_pipe -f tb.f -o sim_int_pipe

./obj_dir/sim_int_pipe > sim.log 2>&1 || true
cat sim.log

if grep -q "^No errors$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

// File: tb/tb_int_pipe.sv
`default_nettype none

module tb_int_pipe;
    timeunit 1ns;
    timeprecision 100ps;

    import core_pkg::*;
    import uop_pkg::*;

    localparam pc_t START_PC   = 32'h0000_0100;
    localparam int  DMEM_WORDS = 16;
    localparam int  WAIT_LIMIT = 200;

    typedef struct packed {
        pc_t       pc;
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } commit_t;

    logic      clk;
    logic      aresetn;
    logic      inst_valid;
    word_t     inst_word;
    logic      inst_ready;
    logic      commit_valid;
    pc_t       commit_pc;
    logic      commit_we;
    reg_addr_t commit_rd;
    word_t     commit_data;

    word_t     model_regs [NUM_REGS];
    word_t     model_mem [DMEM_WORDS];
    pc_t       model_pc;
    commit_t   exp_q [$];
    commit_t   head;
    string     cur_test;
    int        errors;
    int        err_start;
    int        checks;
    int        tests_run;
    int        tests_failed;
    int        refused;
    bit        timed_out;

    int_pipe_top #(
        .RESET_PC   (START_PC),
        .DMEM_WORDS (DMEM_WORDS)
    ) UUT (
        .clk          (clk),
        .aresetn      (aresetn),
        .inst_valid   (inst_valid),
        .inst_word    (inst_word),
        .inst_ready   (inst_ready),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_we    (commit_we),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic word_t make_inst(input logic [3:0] op, input reg_addr_t rd,
                                        input reg_addr_t rj, input reg_addr_t rk,
                                        input logic [11:0] imm);
        return {op, rd, rj, rk, 1'b0, imm};
    endfunction

    // mostly r0..r7 so hazards show up often
    function automatic reg_addr_t pick_reg();
        if ($urandom_range(7, 0) == 0) begin
            return reg_addr_t'($urandom_range(31, 0));
        end
        return reg_addr_t'($urandom_range(7, 0));
    endfunction

    // architectural effect of one instruction, in program order
    task automatic model_step(input word_t w);
        reg_addr_t rd;
        word_t     a;
        word_t     b;
        word_t     imm;
        word_t     res;
        word_t     addr;
        logic      writes;
        commit_t   entry;
        rd         = w[27:23];
        a          = model_regs[w[22:18]];
        b          = model_regs[w[17:13]];
        imm        = {{20{w[11]}}, w[11:0]};
        addr       = a + imm;
        res        = '0;
        writes     = 1'b1;
        entry.data = '0;
        case (w[31:28])
            4'h0: res = a + b;
            4'h1: res = a - b;
            4'h2: res = a & b;
            4'h3: res = a | b;
            4'h4: res = a ^ b;
            4'h5: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4'h6: res = a + imm;
            4'h7: res = imm << 20;
            4'h8: res = model_mem[addr % DMEM_WORDS];
            4'h9: begin
                model_mem[addr % DMEM_WORDS] = b;
                entry.data = b;
                writes     = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        entry.pc = model_pc;
        entry.rd = rd;
        entry.we = writes && (rd != '0);
        if (entry.we) begin
            model_regs[rd] = res;
            entry.data     = res;
        end
        exp_q.push_back(entry);
        model_pc = model_pc + 32'd4;
    endtask

    task automatic send_word(input word_t w);
        int waited;
        if (!timed_out) begin
            inst_valid = 1'b1;
            inst_word  = w;
            waited     = 0;
            @(negedge clk);
            while (!inst_ready && waited < WAIT_LIMIT) begin
                waited++;
                @(negedge clk);
            end
            if (!inst_ready) begin
                $display("%s: timeout waiting for inst_ready", cur_test);
                errors++;
                timed_out = 1'b1;
            end else begin
                model_step(w);
            end
            @(posedge clk);
            #1;
            inst_valid = 1'b0;
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT && !timed_out) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0 && !timed_out) begin
            $display("%s: timeout, %0d commits never arrived", cur_test, exp_q.size());
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        err_start = errors;
    endtask

    task automatic finish_test();
        drain();
        tests_run++;
        if (errors == err_start) begin
            $display("test %s: pass", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", cur_test, errors - err_start);
        end
    endtask

    // outputs have settled by the falling edge
    always @(negedge clk) begin
        if (aresetn) begin
            if (inst_valid && !inst_ready) begin
                refused++;
            end
            if (commit_valid) begin
                if (exp_q.size() == 0) begin
                    $display("%s: commit at pc %h with nothing outstanding", cur_test, commit_pc);
                    errors++;
                end else begin
                    head = exp_q.pop_front();
                    checks++;
                    if (commit_pc !== head.pc) begin
                        $display("mismatch %s pc: expected %h actual %h",
                                 cur_test, head.pc, commit_pc);
                        errors++;
                    end
                    if (commit_we !== head.we) begin
                        $display("mismatch %s we at pc %h: expected %b actual %b",
                                 cur_test, head.pc, head.we, commit_we);
                        errors++;
                    end
                    if (commit_rd !== head.rd) begin
                        $display("mismatch %s rd at pc %h: expected %0d actual %0d",
                                 cur_test, head.pc, head.rd, commit_rd);
                        errors++;
                    end
                    if (commit_data !== head.data) begin
                        $display("mismatch %s data at pc %h: expected %h actual %h",
                                 cur_test, head.pc, head.data, commit_data);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        int        i;
        reg_addr_t rd;
        reg_addr_t prev_rd;
        logic [3:0] op;
        aresetn      = 1'b0;
        inst_valid   = 1'b0;
        inst_word    = '0;
        errors       = 0;
        err_start    = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        refused      = 0;
        timed_out    = 1'b0;
        cur_test     = "reset";
        model_pc     = START_PC;
        for (i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (i = 0; i < DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        void'($urandom(32'h9c0));

        repeat (16) @(posedge clk);
        #1;
        aresetn = 1'b1;
        @(posedge clk);
        #1;
        if (!inst_ready || commit_valid) begin
            $display("pipeline not idle after reset");
            errors++;
        end

        start_test("alu_ops");
        send_word(make_inst(OP_ADDI, 5'd1, 5'd0, 5'd0, 12'h07b));
        send_word(make_inst(OP_ADDI, 5'd2, 5'd0, 5'd0, 12'hfd3));
        send_word(make_inst(OP_LUI, 5'd3, 5'd0, 5'd0, 12'h8a5));
        send_word(make_inst(OP_ADDI, 5'd4, 5'd0, 5'd0, 12'h7ff));
        idle(4);
        // sources settled, so these are independent
        for (i = 0; i < 6; i++) begin
            send_word(make_inst(4'(i), reg_addr_t'(5 + i), 5'd1, 5'd2, 12'h000));
            send_word(make_inst(4'(i), reg_addr_t'(11 + i), 5'd3, 5'd4, 12'h000));
        end
        send_word(make_inst(OP_SLT, 5'd20, 5'd2, 5'd1, 12'h000));
        send_word(make_inst(OP_ADDI, 5'd21, 5'd3, 5'd0, 12'hfff));
        finish_test();

        start_test("back_to_back");
        prev_rd = 5'd1;
        for (i = 0; i < 24; i++) begin
            rd = reg_addr_t'($urandom_range(7, 1));
            op = 4'($urandom_range(6, 0));
            send_word(make_inst(op, rd, prev_rd, pick_reg(), 12'($urandom)));
            prev_rd = rd;
        end
        finish_test();

        start_test("load_use");
        send_word(make_inst(OP_ADDI, 5'd1, 5'd0, 5'd0, 12'h2c4));
        send_word(make_inst(OP_ADDI, 5'd2, 5'd0, 5'd0, 12'h003));
        send_word(make_inst(OP_ST, 5'd0, 5'd2, 5'd1, 12'h001));
        idle(4);
        refused = 0;
        send_word(make_inst(OP_LD, 5'd3, 5'd2, 5'd0, 12'h001));
        send_word(make_inst(OP_ADD, 5'd4, 5'd1, 5'd3, 12'h000));
        send_word(make_inst(OP_ADDI, 5'd5, 5'd0, 5'd0, 12'h011));
        drain();
        checks++;
        if (refused != 1) begin
            $display("mismatch %s refused words: expected 1 actual %0d", cur_test, refused);
            errors++;
        end
        finish_test();

        start_test("memory");
        send_word(make_inst(OP_ADDI, 5'd1, 5'd0, 5'd0, 12'h5a5));
        send_word(make_inst(OP_ADDI, 5'd2, 5'd0, 5'd0, 12'hedd));
        send_word(make_inst(OP_ST, 5'd0, 5'd0, 5'd1, 12'h002));
        send_word(make_inst(OP_ST, 5'd0, 5'd0, 5'd2, 12'h015));
        send_word(make_inst(OP_ST, 5'd0, 5'd0, 5'd1, 12'hfff));
        idle(3);
        send_word(make_inst(OP_LD, 5'd3, 5'd0, 5'd0, 12'h002));
        send_word(make_inst(OP_LD, 5'd4, 5'd0, 5'd0, 12'h005));
        send_word(make_inst(OP_LD, 5'd5, 5'd0, 5'd0, 12'hff2));
        send_word(make_inst(OP_LD, 5'd6, 5'd0, 5'd0, 12'h02f));
        send_word(make_inst(OP_LD, 5'd7, 5'd0, 5'd0, 12'h009));
        send_word(make_inst(OP_LD, 5'd8, 5'd0, 5'd0, 12'h00c));
        finish_test();

        start_test("zero_nop");
        send_word(make_inst(OP_ADDI, 5'd0, 5'd0, 5'd0, 12'h055));
        send_word(make_inst(OP_ADD, 5'd1, 5'd0, 5'd0, 12'h000));
        send_word(make_inst(OP_LD, 5'd0, 5'd0, 5'd0, 12'h002));
        send_word(make_inst(OP_ADDI, 5'd2, 5'd0, 5'd0, 12'h001));
        for (i = 10; i < 16; i++) begin
            send_word(make_inst(4'(i), 5'd9, 5'd1, 5'd2, 12'h0ab));
        end
        send_word(make_inst(OP_ADD, 5'd3, 5'd9, 5'd0, 12'h000));
        finish_test();

        start_test("random_mix");
        for (i = 0; i < 2000; i++) begin
            send_word(make_inst(4'($urandom), pick_reg(), pick_reg(), pick_reg(),
                                12'($urandom)));
            if ($urandom_range(3, 0) == 0) begin
                idle(int'($urandom_range(3, 1)));
            end
        end
        finish_test();

        $display("summary: %0d tests, %0d failed, %0d commits checked, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/int_pipe_checker.sv
`default_nettype none

module int_pipe_checker (
    input wire                      clk,
    input wire                      aresetn,
    input wire                      dec_valid,
    input wire core_pkg::pc_t       dec_pc,
    input wire uop_pkg::opcode_e    dec_op,
    input wire core_pkg::reg_addr_t dec_rd,
    input wire core_pkg::reg_addr_t dec_rj,
    input wire core_pkg::reg_addr_t dec_rk,
    input wire uop_pkg::imm_t       dec_imm,
    input wire                      rr_allowin,
    input wire                      rr_valid,
    input wire                      rr_we
);
    timeunit 1ns;
    timeprecision 100ps;

    // the stalling load reaches result one cycle later
    interlock_single_cycle: assert property (
        @(posedge clk) disable iff (!aresetn)
        !rr_allowin |=> rr_allowin
    ) else $error("load-use interlock lasted two consecutive cycles");

    // decode register must hold its micro-op during a stall
    decode_held: assert property (
        @(posedge clk) disable iff (!aresetn)
        !rr_allowin |=> dec_valid && $stable(dec_pc) && $stable(dec_op) && $stable(dec_rd)
            && $stable(dec_rj) && $stable(dec_rk) && $stable(dec_imm)
    ) else $error("decode payload changed while rr_allowin was low");

    // a stall puts a bubble into execute that never writes
    bubble_no_write: assert property (
        @(posedge clk) disable iff (!aresetn)
        !rr_allowin |=> !rr_valid && !rr_we
    ) else $error("stall did not send a bubble without write enable into execute");

endmodule

bind reg_read_stage int_pipe_checker u_checker (
    .clk        (clk),
    .aresetn    (aresetn),
    .dec_valid  (dec_valid),
    .dec_pc     (dec_pc),
    .dec_op     (dec_op),
    .dec_rd     (dec_rd),
    .dec_rj     (dec_rj),
    .dec_rk     (dec_rk),
    .dec_imm    (dec_imm),
    .rr_allowin (rr_allowin),
    .rr_valid   (rr_valid),
    .rr_we      (rr_we)
);

`default_nettype wire

// File: src/int_pipe_top.sv
`default_nettype none

module int_pipe_top #(
    parameter core_pkg::pc_t RESET_PC   = '0,
    parameter int            DMEM_WORDS = 16
) (
    input  wire                  clk,
    input  wire                  aresetn,
    input  wire                  inst_valid,
    input  wire core_pkg::word_t inst_word,
    output logic                 inst_ready,
    output logic                 commit_valid,
    output core_pkg::pc_t        commit_pc,
    output logic                 commit_we,
    output core_pkg::reg_addr_t  commit_rd,
    output core_pkg::word_t      commit_data
);
    import core_pkg::*;
    import uop_pkg::*;

    logic      dec_valid, dec_uses_rj, dec_uses_rk, dec_we;
    pc_t       dec_pc;
    opcode_e   dec_op;
    alu_op_e   dec_alu_op;
    reg_addr_t dec_rd, dec_rj, dec_rk;
    imm_t      dec_imm;
    word_t     rf_rdata_a, rf_rdata_b;

    logic      rr_allowin, rr_valid, rr_we;
    pc_t       rr_pc;
    opcode_e   rr_op;
    alu_op_e   rr_alu_op;
    reg_addr_t rr_rd;
    word_t     rr_a, rr_b;
    imm_t      rr_imm;

    logic      ex_valid, ex_we, ex_is_load, ex_fwd_valid;
    pc_t       ex_pc;
    opcode_e   ex_op;
    reg_addr_t ex_rd, ex_fwd_rd;
    word_t     ex_value, ex_store_data, ex_fwd_data;

    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    decode_stage #(
        .RESET_PC (RESET_PC)
    ) u_decode (
        .clk         (clk),
        .aresetn     (aresetn),
        .inst_valid  (inst_valid),
        .inst_word   (inst_word),
        .inst_ready  (inst_ready),
        .rr_allowin  (rr_allowin),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_op      (dec_op),
        .dec_alu_op  (dec_alu_op),
        .dec_rd      (dec_rd),
        .dec_rj      (dec_rj),
        .dec_rk      (dec_rk),
        .dec_imm     (dec_imm),
        .dec_uses_rj (dec_uses_rj),
        .dec_uses_rk (dec_uses_rk),
        .dec_we      (dec_we)
    );

    regfile u_regfile (
        .clk     (clk),
        .aresetn (aresetn),
        .raddr_a (dec_rj),
        .raddr_b (dec_rk),
        .we      (wb_we),
        .waddr   (wb_rd),
        .wdata   (wb_data),
        .rdata_a (rf_rdata_a),
        .rdata_b (rf_rdata_b)
    );

    // interlock compares against the load now in execute
    reg_read_stage u_reg_read (
        .clk          (clk),
        .aresetn      (aresetn),
        .dec_valid    (dec_valid),
        .dec_pc       (dec_pc),
        .dec_op       (dec_op),
        .dec_alu_op   (dec_alu_op),
        .dec_rd       (dec_rd),
        .dec_rj       (dec_rj),
        .dec_rk       (dec_rk),
        .dec_imm      (dec_imm),
        .dec_uses_rj  (dec_uses_rj),
        .dec_uses_rk  (dec_uses_rk),
        .dec_we       (dec_we),
        .rf_rdata_a   (rf_rdata_a),
        .rf_rdata_b   (rf_rdata_b),
        .ex_is_load   (ex_is_load),
        .ex_rd        (ex_fwd_rd),
        .ex_fwd_valid (ex_fwd_valid),
        .ex_fwd_rd    (ex_fwd_rd),
        .ex_fwd_data  (ex_fwd_data),
        .wb_we        (wb_we),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .rr_allowin   (rr_allowin),
        .rr_valid     (rr_valid),
        .rr_pc        (rr_pc),
        .rr_op        (rr_op),
        .rr_alu_op    (rr_alu_op),
        .rr_rd        (rr_rd),
        .rr_we        (rr_we),
        .rr_a         (rr_a),
        .rr_b         (rr_b),
        .rr_imm       (rr_imm)
    );

    execute_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_execute (
        .clk           (clk),
        .aresetn       (aresetn),
        .rr_valid      (rr_valid),
        .rr_pc         (rr_pc),
        .rr_op         (rr_op),
        .rr_alu_op     (rr_alu_op),
        .rr_rd         (rr_rd),
        .rr_we         (rr_we),
        .rr_a          (rr_a),
        .rr_b          (rr_b),
        .rr_imm        (rr_imm),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_op         (ex_op),
        .ex_rd         (ex_rd),
        .ex_we         (ex_we),
        .ex_value      (ex_value),
        .ex_store_data (ex_store_data),
        .ex_is_load    (ex_is_load),
        .ex_fwd_valid  (ex_fwd_valid),
        .ex_fwd_rd     (ex_fwd_rd),
        .ex_fwd_data   (ex_fwd_data)
    );

    result_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_result (
        .clk           (clk),
        .aresetn       (aresetn),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_op         (ex_op),
        .ex_rd         (ex_rd),
        .ex_we         (ex_we),
        .ex_value      (ex_value),
        .ex_store_data (ex_store_data),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .commit_valid  (commit_valid),
        .commit_pc     (commit_pc),
        .commit_we     (commit_we),
        .commit_rd     (commit_rd),
        .commit_data   (commit_data)
    );

endmodule

`default_nettype wire

// File: src/result_stage.sv
`default_nettype none

module result_stage #(
    parameter int DMEM_WORDS = 16
) (
    input  wire                      clk,
    input  wire                      aresetn,
    input  wire                      ex_valid,
    input  wire core_pkg::pc_t       ex_pc,
    input  wire uop_pkg::opcode_e    ex_op,
    input  wire core_pkg::reg_addr_t ex_rd,
    input  wire                      ex_we,
    input  wire core_pkg::word_t     ex_value,
    input  wire core_pkg::word_t     ex_store_data,
    output logic                     wb_we,
    output core_pkg::reg_addr_t      wb_rd,
    output core_pkg::word_t          wb_data,
    output logic                     commit_valid,
    output core_pkg::pc_t            commit_pc,
    output logic                     commit_we,
    output core_pkg::reg_addr_t      commit_rd,
    output core_pkg::word_t          commit_data
);
    import core_pkg::*;
    import uop_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    word_t         dmem [DMEM_WORDS];
    logic [AW-1:0] idx;
    logic          is_store;
    word_t         ld_data;

    assign idx      = ex_value[AW-1:0];
    assign is_store = ex_valid && ex_op == OP_ST;
    assign ld_data  = dmem[idx];

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (is_store) begin
            dmem[idx] <= ex_store_data;
        end
    end

    // write-back also feeds the result bypass
    assign wb_we   = ex_valid && ex_we;
    assign wb_rd   = ex_rd;
    assign wb_data = (ex_op == OP_LD) ? ld_data : ex_value;

    assign commit_valid = ex_valid;
    assign commit_pc    = ex_pc;
    assign commit_we    = wb_we;
    assign commit_rd    = ex_rd;

    // stored value for stores, zero when nothing is written
    always_comb begin
        if (ex_op == OP_ST) begin
            commit_data = ex_store_data;
        end else if (wb_we) begin
            commit_data = wb_data;
        end else begin
            commit_data = '0;
        end
    end

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`default_nettype none

module execute_stage #(
    parameter int DMEM_WORDS = 16
) (
    input  wire                      clk,
    input  wire                      aresetn,
    input  wire                      rr_valid,
    input  wire core_pkg::pc_t       rr_pc,
    input  wire uop_pkg::opcode_e    rr_op,
    input  wire uop_pkg::alu_op_e    rr_alu_op,
    input  wire core_pkg::reg_addr_t rr_rd,
    input  wire                      rr_we,
    input  wire core_pkg::word_t     rr_a,
    input  wire core_pkg::word_t     rr_b,
    input  wire uop_pkg::imm_t       rr_imm,
    output logic                     ex_valid,
    output core_pkg::pc_t            ex_pc,
    output uop_pkg::opcode_e         ex_op,
    output core_pkg::reg_addr_t      ex_rd,
    output logic                     ex_we,
    output core_pkg::word_t          ex_value,
    output core_pkg::word_t          ex_store_data,
    output logic                     ex_is_load,
    output logic                     ex_fwd_valid,
    output core_pkg::reg_addr_t      ex_fwd_rd,
    output core_pkg::word_t          ex_fwd_data
);
    import core_pkg::*;
    import uop_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    word_t alu_res;
    word_t mem_addr;
    logic  is_mem;

    always_comb begin
        case (rr_alu_op)
            ALU_ADD:    alu_res = rr_a + rr_b;
            ALU_SUB:    alu_res = rr_a - rr_b;
            ALU_AND:    alu_res = rr_a & rr_b;
            ALU_OR:     alu_res = rr_a | rr_b;
            ALU_XOR:    alu_res = rr_a ^ rr_b;
            ALU_SLT:    alu_res = word_t'($signed(rr_a) < $signed(rr_b));
            ALU_PASS_B: alu_res = rr_b;
            default:    alu_res = '0;
        endcase
    end

    // word index, wraps at the memory depth
    assign mem_addr = rr_a + rr_imm;
    assign is_mem   = rr_op inside {OP_LD, OP_ST};

    // bypass and interlock look at the op now in execute
    assign ex_fwd_valid = rr_valid && rr_we && rr_op != OP_LD;
    assign ex_fwd_rd    = rr_rd;
    assign ex_fwd_data  = alu_res;
    assign ex_is_load   = rr_valid && rr_we && rr_op == OP_LD;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            ex_valid <= 1'b0;
            ex_we    <= 1'b0;
        end else begin
            ex_valid <= rr_valid;
            ex_we    <= rr_we;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc         <= rr_pc;
        ex_op         <= rr_op;
        ex_rd         <= rr_rd;
        ex_value      <= is_mem ? word_t'(mem_addr[AW-1:0]) : alu_res;
        ex_store_data <= rr_b;
    end

endmodule

`default_nettype wire

// File: src/reg_read_stage.sv
`default_nettype none

module reg_read_stage (
    input  wire                      clk,
    input  wire                      aresetn,
    input  wire                      dec_valid,
    input  wire core_pkg::pc_t       dec_pc,
    input  wire uop_pkg::opcode_e    dec_op,
    input  wire uop_pkg::alu_op_e    dec_alu_op,
    input  wire core_pkg::reg_addr_t dec_rd,
    input  wire core_pkg::reg_addr_t dec_rj,
    input  wire core_pkg::reg_addr_t dec_rk,
    input  wire uop_pkg::imm_t       dec_imm,
    input  wire                      dec_uses_rj,
    input  wire                      dec_uses_rk,
    input  wire                      dec_we,
    input  wire core_pkg::word_t     rf_rdata_a,
    input  wire core_pkg::word_t     rf_rdata_b,
    input  wire                      ex_is_load,
    input  wire core_pkg::reg_addr_t ex_rd,
    input  wire                      ex_fwd_valid,
    input  wire core_pkg::reg_addr_t ex_fwd_rd,
    input  wire core_pkg::word_t     ex_fwd_data,
    input  wire                      wb_we,
    input  wire core_pkg::reg_addr_t wb_rd,
    input  wire core_pkg::word_t     wb_data,
    output logic                     rr_allowin,
    output logic                     rr_valid,
    output core_pkg::pc_t            rr_pc,
    output uop_pkg::opcode_e         rr_op,
    output uop_pkg::alu_op_e         rr_alu_op,
    output core_pkg::reg_addr_t      rr_rd,
    output logic                     rr_we,
    output core_pkg::word_t          rr_a,
    output core_pkg::word_t          rr_b,
    output uop_pkg::imm_t            rr_imm
);
    import core_pkg::*;
    import uop_pkg::*;

    logic  load_use;
    logic  go;
    word_t opnd_a;
    word_t opnd_b;

    // zero, then execute, then result, then the register file
    function automatic word_t bypass(input reg_addr_t src, input word_t rf_val);
        if (src == '0) begin
            return '0;
        end
        if (ex_fwd_valid && ex_fwd_rd == src) begin
            return ex_fwd_data;
        end
        if (wb_we && wb_rd == src) begin
            return wb_data;
        end
        return rf_val;
    endfunction

    // load data only exists in the result stage, one cycle too late
    always_comb begin
        load_use = dec_valid && ex_is_load &&
                   ((dec_uses_rj && dec_rj == ex_rd) ||
                    (dec_uses_rk && dec_rk == ex_rd));
        rr_allowin = !load_use;
        go         = dec_valid && !load_use;

        opnd_a = bypass(dec_rj, rf_rdata_a);
        if (dec_op inside {OP_ADDI, OP_LUI}) begin
            opnd_b = dec_imm;
        end else begin
            opnd_b = bypass(dec_rk, rf_rdata_b);
        end
    end

    // execute always accepts, a stall sends a bubble
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            rr_valid <= 1'b0;
            rr_we    <= 1'b0;
        end else begin
            rr_valid <= go;
            rr_we    <= go && dec_we;
        end
    end

    always_ff @(posedge clk) begin
        rr_pc     <= dec_pc;
        rr_op     <= dec_op;
        rr_alu_op <= dec_alu_op;
        rr_rd     <= dec_rd;
        rr_a      <= opnd_a;
        rr_b      <= opnd_b;
        rr_imm    <= dec_imm;
    end

endmodule

`default_nettype wire

// File: src/regfile.sv
`default_nettype none

module regfile (
    input  wire                  clk,
    input  wire                  aresetn,
    input  wire core_pkg::reg_addr_t raddr_a,
    input  wire core_pkg::reg_addr_t raddr_b,
    input  wire                  we,
    input  wire core_pkg::reg_addr_t waddr,
    input  wire core_pkg::word_t wdata,
    output core_pkg::word_t      rdata_a,
    output core_pkg::word_t      rdata_b
);
    import core_pkg::*;

    word_t regs [NUM_REGS];

    // write-first, r0 hard-wired to zero
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (we && waddr == addr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata_a = read_port(raddr_a);
        rdata_b = read_port(raddr_b);
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: src/decode_stage.sv
`default_nettype none

module decode_stage #(
    parameter core_pkg::pc_t RESET_PC = '0
) (
    input  wire                      clk,
    input  wire                      aresetn,
    input  wire                      inst_valid,
    input  wire core_pkg::word_t     inst_word,
    output logic                     inst_ready,
    input  wire                      rr_allowin,
    output logic                     dec_valid,
    output core_pkg::pc_t            dec_pc,
    output uop_pkg::opcode_e         dec_op,
    output uop_pkg::alu_op_e         dec_alu_op,
    output core_pkg::reg_addr_t      dec_rd,
    output core_pkg::reg_addr_t      dec_rj,
    output core_pkg::reg_addr_t      dec_rk,
    output uop_pkg::imm_t            dec_imm,
    output logic                     dec_uses_rj,
    output logic                     dec_uses_rk,
    output logic                     dec_we
);
    import core_pkg::*;
    import uop_pkg::*;

    pc_t       pc_cnt;
    opcode_e   op;
    alu_op_e   alu_op;
    reg_addr_t rd;
    imm_t      imm;
    logic      uses_rj;
    logic      uses_rk;
    logic      we;
    logic      accept;

    // register free or draining into register read this cycle
    assign inst_ready = !dec_valid || rr_allowin;
    assign accept     = inst_valid && inst_ready;
    assign rd         = inst_word[RD_HI:RD_LO];

    always_comb begin
        op      = OP_NOP;
        uses_rj = 1'b0;
        uses_rk = 1'b0;
        imm     = {{($bits(imm_t) - IMM_HI - 1){inst_word[IMM_HI]}},
                   inst_word[IMM_HI:IMM_LO]};
        case (inst_word[OPC_HI:OPC_LO])
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_ST: begin
                op      = opcode_e'(inst_word[OPC_HI:OPC_LO]);
                uses_rj = 1'b1;
                uses_rk = 1'b1;
            end
            OP_ADDI, OP_LD: begin
                op      = opcode_e'(inst_word[OPC_HI:OPC_LO]);
                uses_rj = 1'b1;
            end
            OP_LUI: begin
                op  = OP_LUI;
                imm = imm << LUI_SHIFT;
            end
            default: ;
        endcase

        case (op)
            OP_SUB:  alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            OP_XOR:  alu_op = ALU_XOR;
            OP_SLT:  alu_op = ALU_SLT;
            OP_LUI:  alu_op = ALU_PASS_B;
            default: alu_op = ALU_ADD;
        endcase

        // r0 is never written
        we = !(op inside {OP_ST, OP_NOP}) && (rd != '0);
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            dec_valid <= 1'b0;
            pc_cnt    <= RESET_PC;
        end else if (accept) begin
            dec_valid <= 1'b1;
            pc_cnt    <= pc_cnt + pc_t'(PC_STEP);
        end else if (rr_allowin) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_pc      <= pc_cnt;
            dec_op      <= op;
            dec_alu_op  <= alu_op;
            dec_rd      <= rd;
            dec_rj      <= inst_word[RJ_HI:RJ_LO];
            dec_rk      <= inst_word[RK_HI:RK_LO];
            dec_imm     <= imm;
            dec_uses_rj <= uses_rj;
            dec_uses_rk <= uses_rk;
            dec_we      <= we;
        end
    end

endmodule

`default_nettype wire

// File: src/uop_pkg.sv
`default_nettype none

package uop_pkg;

    // major opcode, unlisted codes are treated as nop
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_SLT  = 4'h5,
        OP_ADDI = 4'h6,
        OP_LUI  = 4'h7,
        OP_LD   = 4'h8,
        OP_ST   = 4'h9,
        OP_NOP  = 4'hf
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

    // sign-extended immediate
    typedef logic [31:0] imm_t;

    // instruction field positions
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 28;
    localparam int RD_HI  = 27;
    localparam int RD_LO  = 23;
    localparam int RJ_HI  = 22;
    localparam int RJ_LO  = 18;
    localparam int RK_HI  = 17;
    localparam int RK_LO  = 13;
    localparam int IMM_HI = 11;
    localparam int IMM_LO = 0;

    localparam int LUI_SHIFT = 20;

endpackage

`default_nettype wire

// File: src/core_pkg.sv
`default_nettype none

package core_pkg;

    // operand, result and memory word
    typedef logic [31:0] word_t;

    // byte address of an instruction
    typedef logic [31:0] pc_t;

    // architectural register index
    typedef logic [4:0] reg_addr_t;

    localparam int NUM_REGS = 32;

    // one instruction word per pc step
    localparam int PC_STEP = 4;

endpackage

`default_nettype wire
